/* Makefile */
VERILATOR ?= verilator
TOP       ?= exc_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert -j 0
PASS_MSG  := PASS: all tests

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* src/cp0_regs.sv */
`timescale 1ns/1ps

module cp0_regs (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        mtc0_we,
    input  logic [4:0]  cp0_addr,
    input  logic [31:0] cp0_wdata,
    input  logic [5:0]  hw_int,
    input  logic        wr_exp,
    input  logic        clear_exl,
    input  logic [4:0]  exp_code,
    input  logic [31:0] epc,
    input  logic [31:0] badvaddr,
    input  logic        badvaddr_we,
    input  logic        bd,
    output logic [31:0] cp0_rdata,
    output logic        allow_int,
    output logic [7:0]  interrupt_flag,
    output logic [31:0] epc_value,
    output logic        status_bev
);

    import exc_pkg::*;

    status_u     status_q;
    status_u     wr_status;
    logic        cause_bd_q;
    logic [4:0]  cause_code_q;
    logic [1:0]  ip_sw_q;
    logic [7:0]  cause_ip;
    logic [31:0] cause_word;
    logic [31:0] epc_q;
    logic [31:0] badvaddr_q;
    logic [31:0] count_q;
    logic [31:0] compare_q;
    logic        tick_q;
    logic        timer_q;
    logic        sw_status;
    logic        sw_cause;
    logic        sw_epc;
    logic        sw_count;
    logic        sw_compare;

    assign sw_status  = mtc0_we && (cp0_addr == cp0_status);
    assign sw_cause   = mtc0_we && (cp0_addr == cp0_cause);
    assign sw_epc     = mtc0_we && (cp0_addr == cp0_epc);
    assign sw_count   = mtc0_we && (cp0_addr == cp0_count);
    assign sw_compare = mtc0_we && (cp0_addr == cp0_compare);

    assign wr_status.raw = cp0_wdata;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // status
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reserved fields keep their reset value of zero.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            status_q.raw <= status_reset;
        end else begin
            if (sw_status) begin
                status_q.f.cu0 <= wr_status.f.cu0;
                status_q.f.bev <= wr_status.f.bev;
                status_q.f.im  <= wr_status.f.im;
                status_q.f.ie  <= wr_status.f.ie;
            end
            if (wr_exp) begin
                status_q.f.exl <= 1'b1;
            end else if (clear_exl) begin
                status_q.f.exl <= 1'b0;
            end else if (sw_status) begin
                status_q.f.exl <= wr_status.f.exl;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // cause
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cause_bd_q   <= 1'b0;
            cause_code_q <= 5'd0;
            ip_sw_q      <= 2'b00;
        end else begin
            if (wr_exp) begin
                cause_bd_q   <= bd;
                cause_code_q <= exp_code;
            end
            if (sw_cause) begin
                ip_sw_q <= cp0_wdata[9:8]; // only the software interrupt bits are writable.
            end
        end
    end

    // the timer shares IP7 with the top hardware line.
    assign cause_ip   = {hw_int[5] | timer_q, hw_int[4:0], ip_sw_q};
    assign cause_word = {cause_bd_q, timer_q, 14'd0, cause_ip, 1'b0, cause_code_q, 2'b00};

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // count and compare
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            tick_q    <= 1'b0;
            count_q   <= 32'd0;
            compare_q <= 32'hFFFF_FFFF; // far from count, so no early timer interrupt.
            timer_q   <= 1'b0;
        end else begin
            tick_q <= ~tick_q;
            if (sw_count) begin
                count_q <= cp0_wdata;
            end else if (tick_q) begin
                count_q <= count_q + 32'd1; // half the core clock rate.
            end
            if (sw_compare) begin
                compare_q <= cp0_wdata;
            end
            if (sw_compare) begin
                timer_q <= 1'b0;
            end else if (count_q == compare_q) begin
                timer_q <= 1'b1;
            end
        end
    end

    // epc and badvaddr carry addresses only.
    always_ff @(posedge clk) begin
        if (wr_exp) begin
            epc_q <= epc;
        end else if (sw_epc) begin
            epc_q <= cp0_wdata;
        end
        if (badvaddr_we) begin
            badvaddr_q <= badvaddr;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // outputs
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign allow_int      = status_q.f.ie & ~status_q.f.exl;
    assign interrupt_flag = cause_ip & status_q.f.im;
    assign epc_value      = epc_q;
    assign status_bev     = status_q.f.bev;

    always_comb begin
        case (cp0_addr)
            cp0_status:   cp0_rdata = status_q.raw;
            cp0_cause:    cp0_rdata = cause_word;
            cp0_epc:      cp0_rdata = epc_q;
            cp0_badvaddr: cp0_rdata = badvaddr_q;
            cp0_count:    cp0_rdata = count_q;
            cp0_compare:  cp0_rdata = compare_q;
            default:      cp0_rdata = 32'd0; // unimplemented registers read as zero.
        endcase
    end

endmodule

/* src/exc_pkg.sv */
package exc_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // exception codes, as written to Cause.ExcCode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam logic [4:0] ex_int  = 5'd0;  // interrupt.
    localparam logic [4:0] ex_mod  = 5'd1;  // store to a clean page.
    localparam logic [4:0] ex_tlbl = 5'd2;  // tlb fault on load or fetch.
    localparam logic [4:0] ex_tlbs = 5'd3;  // tlb fault on store.
    localparam logic [4:0] ex_adel = 5'd4;  // address error on load or fetch.
    localparam logic [4:0] ex_ades = 5'd5;  // address error on store.
    localparam logic [4:0] ex_sys  = 5'd8;
    localparam logic [4:0] ex_bp   = 5'd9;
    localparam logic [4:0] ex_ri   = 5'd10; // reserved instruction.
    localparam logic [4:0] ex_ov   = 5'd12;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // handler vectors
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam logic [31:0] boot_base      = 32'hBFC0_0200; // used while Status.BEV is set.
    localparam logic [31:0] normal_base    = 32'h8000_0000;
    localparam logic [31:0] refill_offset  = 32'h0000_0000; // tlb misses only.
    localparam logic [31:0] general_offset = 32'h0000_0180;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // cp0 register numbers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam logic [4:0] cp0_badvaddr = 5'd8;
    localparam logic [4:0] cp0_count    = 5'd9;
    localparam logic [4:0] cp0_compare  = 5'd11;
    localparam logic [4:0] cp0_status   = 5'd12;
    localparam logic [4:0] cp0_cause    = 5'd13;
    localparam logic [4:0] cp0_epc      = 5'd14;

    // bev set, everything else clear.
    localparam logic [31:0] status_reset = 32'h0040_0000;

    // Status is written by software as a whole word and read by the logic
    // one field at a time.
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [2:0] rsv31_29;
            logic       cu0;       // coprocessor 0 usable in user mode.
            logic [4:0] rsv27_23;
            logic       bev;       // boot exception vectors.
            logic [5:0] rsv21_16;
            logic [7:0] im;        // interrupt mask.
            logic [5:0] rsv7_2;
            logic       exl;       // exception level.
            logic       ie;        // global interrupt enable.
        } f;
    } status_u;

endpackage

/* src/exc_priority.sv */
`timescale 1ns/1ps

module exc_priority (
    input  logic        clk,
    input  logic        arst_n,
    input  logic [31:0] exc_pc,
    input  logic [31:0] pc,
    input  logic [31:0] data_vaddr,
    input  logic        data_we,
    input  logic        data_miss,
    input  logic        inst_miss,
    input  logic        data_illegal,
    input  logic        inst_illegal,
    input  logic        data_dirty,
    input  logic        data_invalid,
    input  logic        inst_invalid,
    input  logic        eret,
    input  logic        brk,
    input  logic        syscall,
    input  logic        unknown_inst,
    input  logic        overflow,
    input  logic        in_delayslot,
    input  logic        allow_int,
    input  logic [7:0]  interrupt_flag,
    input  logic [31:0] epc_value,
    input  logic        status_bev,
    input  logic        inst_data_ok,
    input  logic        icache_stall,
    input  logic        inst_uncached,
    output logic        flush,
    output logic        wr_exp,
    output logic        clear_exl,
    output logic [4:0]  exp_code,
    output logic [31:0] epc,
    output logic [31:0] badvaddr,
    output logic        badvaddr_we,
    output logic        bd,
    output logic [31:0] exception_new_pc,
    output logic        now_exp
);

    import exc_pkg::*;

    logic        int_req;
    logic        exc_any;
    logic [4:0]  code_n;
    logic        refill_n;
    logic        bv_we_n;
    logic        bv_inst_n;
    logic [31:0] vec_base;
    logic        fetch_done;

    assign int_req  = allow_int & (|interrupt_flag);
    assign vec_base = status_bev ? boot_base : normal_base;
    assign now_exp  = exc_any | eret; // eret redirects and flushes like a fault.

    // one chain, highest priority first.
    always_comb begin
        exc_any   = 1'b1;
        code_n    = ex_int;
        refill_n  = 1'b0;
        bv_we_n   = 1'b0;
        bv_inst_n = 1'b0;
        if (int_req) begin
            code_n = ex_int;
        end else if (data_dirty && data_we) begin
            code_n  = ex_mod;
            bv_we_n = 1'b1;
        end else if (inst_miss) begin
            code_n    = ex_tlbl;
            refill_n  = 1'b1;
            bv_we_n   = 1'b1;
            bv_inst_n = 1'b1;
        end else if (data_miss) begin
            code_n   = data_we ? ex_tlbs : ex_tlbl;
            refill_n = 1'b1;
            bv_we_n  = 1'b1;
        end else if (inst_invalid) begin
            code_n    = ex_tlbl;
            bv_we_n   = 1'b1;
            bv_inst_n = 1'b1;
        end else if (data_invalid) begin
            code_n  = data_we ? ex_tlbs : ex_tlbl;
            bv_we_n = 1'b1;
        end else if (inst_illegal) begin
            code_n    = ex_adel;
            bv_we_n   = 1'b1;
            bv_inst_n = 1'b1;
        end else if (data_illegal) begin
            code_n  = data_we ? ex_ades : ex_adel;
            bv_we_n = 1'b1;
        end else if (syscall) begin
            code_n = ex_sys;
        end else if (brk) begin
            code_n = ex_bp;
        end else if (unknown_inst) begin
            code_n = ex_ri;
        end else if (overflow) begin
            code_n = ex_ov;
        end else begin
            exc_any = 1'b0;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // flush release
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // the flush holds until fetch has settled on the new stream.
    assign fetch_done = inst_data_ok | (~icache_stall & ~inst_uncached);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            flush       <= 1'b0;
            wr_exp      <= 1'b0;
            clear_exl   <= 1'b0;
            badvaddr_we <= 1'b0;
            exp_code    <= 5'd0;
        end else begin
            wr_exp      <= exc_any;
            clear_exl   <= eret & ~exc_any;
            badvaddr_we <= bv_we_n;  // only ever set together with exc_any.
            if (exc_any) begin
                exp_code <= code_n;
            end else if (!eret) begin
                exp_code <= 5'd0;
            end
            if (now_exp) begin
                flush <= 1'b1;
            end else if (fetch_done) begin
                flush <= 1'b0;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // recorded state and redirect target
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (exc_any) begin
            epc              <= exc_pc;
            bd               <= in_delayslot;
            exception_new_pc <= vec_base + (refill_n ? refill_offset : general_offset);
            if (bv_we_n) begin
                badvaddr <= bv_inst_n ? pc : data_vaddr;
            end
        end else if (eret) begin
            exception_new_pc <= epc_value;
        end
    end

endmodule

/* src/exc_top.sv */
`timescale 1ns/1ps

module exc_top (
    input  logic        clk,
    input  logic        arst_n,
    input  logic [31:0] exc_pc,
    input  logic [31:0] pc,
    input  logic [31:0] data_vaddr,
    input  logic        data_we,
    input  logic        data_miss,
    input  logic        inst_miss,
    input  logic        data_illegal,
    input  logic        inst_illegal,
    input  logic        data_dirty,
    input  logic        data_invalid,
    input  logic        inst_invalid,
    input  logic        eret,
    input  logic        brk,
    input  logic        syscall,
    input  logic        unknown_inst,
    input  logic        overflow,
    input  logic        in_delayslot,
    input  logic        inst_data_ok,
    input  logic        icache_stall,
    input  logic        inst_uncached,
    input  logic [5:0]  hw_int,
    input  logic        mtc0_we,
    input  logic [4:0]  cp0_addr,
    input  logic [31:0] cp0_wdata,
    output logic        flush,
    output logic [31:0] exception_new_pc,
    output logic        now_exp,
    output logic [31:0] cp0_rdata
);

    // cp0 state seen by the priority unit.
    logic        allow_int;
    logic [7:0]  interrupt_flag;
    logic [31:0] epc_value;
    logic        status_bev;

    // capture strobes from the priority unit.
    logic        wr_exp;
    logic        clear_exl;
    logic [4:0]  exp_code;
    logic [31:0] epc;
    logic [31:0] badvaddr;
    logic        badvaddr_we;
    logic        bd;

    exc_priority u_prio (
        .clk(clk), .arst_n(arst_n),
        .exc_pc(exc_pc), .pc(pc), .data_vaddr(data_vaddr),
        .data_we(data_we), .data_miss(data_miss), .inst_miss(inst_miss),
        .data_illegal(data_illegal), .inst_illegal(inst_illegal),
        .data_dirty(data_dirty), .data_invalid(data_invalid), .inst_invalid(inst_invalid),
        .eret(eret), .brk(brk), .syscall(syscall), .unknown_inst(unknown_inst),
        .overflow(overflow), .in_delayslot(in_delayslot),
        .allow_int(allow_int), .interrupt_flag(interrupt_flag),
        .epc_value(epc_value), .status_bev(status_bev),
        .inst_data_ok(inst_data_ok), .icache_stall(icache_stall),
        .inst_uncached(inst_uncached),
        .flush(flush), .wr_exp(wr_exp), .clear_exl(clear_exl), .exp_code(exp_code),
        .epc(epc), .badvaddr(badvaddr), .badvaddr_we(badvaddr_we), .bd(bd),
        .exception_new_pc(exception_new_pc), .now_exp(now_exp)
    );

    cp0_regs u_cp0 (
        .clk(clk), .arst_n(arst_n),
        .mtc0_we(mtc0_we), .cp0_addr(cp0_addr), .cp0_wdata(cp0_wdata), .hw_int(hw_int),
        .wr_exp(wr_exp), .clear_exl(clear_exl), .exp_code(exp_code), .epc(epc),
        .badvaddr(badvaddr), .badvaddr_we(badvaddr_we), .bd(bd),
        .cp0_rdata(cp0_rdata), .allow_int(allow_int), .interrupt_flag(interrupt_flag),
        .epc_value(epc_value), .status_bev(status_bev)
    );

endmodule

/* test/exc_checker.sv */
`timescale 1ns/1ps

module exc_checker (
    input logic clk,
    input logic arst_n,
    input logic flush,
    input logic wr_exp,
    input logic clear_exl,
    input logic badvaddr_we,
    input logic now_exp
);

    int unsigned n_both = 0;
    int unsigned n_bv = 0;
    int unsigned n_flush = 0;
    int unsigned n_quiet = 0;
    int unsigned fails;
    logic        seen_exc;

    assign fails = n_both + n_bv + n_flush + n_quiet;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            seen_exc <= 1'b0;
        end else if (now_exp) begin
            seen_exc <= 1'b1; // first redirect since reset.
        end
    end

    a_exl_strobes: assert property (@(posedge clk) disable iff (!arst_n)
        !(clear_exl && wr_exp))
        else begin
            $error("clear_exl and wr_exp are high in the same cycle");
            n_both++;
        end

    a_bv_we: assert property (@(posedge clk) disable iff (!arst_n) badvaddr_we |-> wr_exp)
        else begin
            $error("badvaddr_we is high without wr_exp");
            n_bv++;
        end

    a_flush: assert property (@(posedge clk) disable iff (!arst_n) wr_exp |-> flush)
        else begin
            $error("wr_exp is high without flush");
            n_flush++;
        end

    a_quiet: assert property (@(posedge clk) disable iff (!arst_n) !seen_exc |-> !flush)
        else begin
            $error("flush rose before any exception after reset");
            n_quiet++;
        end

endmodule

bind exc_top exc_checker u_chk (
    .clk(clk),
    .arst_n(arst_n),
    .flush(flush),
    .wr_exp(wr_exp),
    .clear_exl(clear_exl),
    .badvaddr_we(badvaddr_we),
    .now_exp(now_exp)
);

/* test/exc_tb.sv */
`timescale 1ns/1ps

module exc_tb;

    import exc_pkg::*;

    typedef struct packed {
        logic [10:0] mask;    // bit 0 is the highest priority fault.
        logic        we;
        logic [4:0]  code;
        logic [31:0] offset;
        logic        from_pc; // badvaddr comes from pc, else from data_vaddr.
        logic        bv_we;
    } row_t;

    logic        clk = 1'b0;
    logic        arst_n;
    logic [31:0] exc_pc, pc, data_vaddr, cp0_wdata;
    logic        data_we, data_miss, inst_miss, data_illegal, inst_illegal, data_dirty;
    logic        data_invalid, inst_invalid, eret, brk, syscall, unknown_inst, overflow;
    logic        in_delayslot, inst_data_ok, icache_stall, inst_uncached, mtc0_we;
    logic [5:0]  hw_int;
    logic [4:0]  cp0_addr;
    logic        flush, now_exp;
    logic [31:0] exception_new_pc, cp0_rdata;

    row_t        rows [14];
    logic [15:0] lfsr = 16'd16560;
    int          n_err = 0;
    int          n_checks = 0;
    int          n_tests = 0;
    int          n_failed = 0;
    int          err_at_start = 0;

    exc_top u_dut (.*);

    always #2 clk = ~clk;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] r;
        r = 32'd0;
        for (int i = 0; i < n; i++) begin
            r    = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1); // galois taps.
        end
        return r;
    endfunction

    function automatic logic [31:0] status_word(input logic bev, input logic [7:0] im,
                                               input logic ie);
        return {9'd0, bev, 6'd0, im, 6'd0, 1'b0, ie};
    endfunction

    function automatic logic [4:0] code_of(input int b, input logic we);
        case (b)
            0:       return ex_mod;
            1, 3:    return ex_tlbl;
            2, 4:    return we ? ex_tlbs : ex_tlbl;
            5:       return ex_adel;
            6:       return we ? ex_ades : ex_adel;
            7:       return ex_sys;
            8:       return ex_bp;
            9:       return ex_ri;
            default: return ex_ov;
        endcase
    endfunction

    // scanned from the bottom up, so the highest set fault is written last.
    function automatic logic [4:0] top_code(input logic [10:0] m, input logic we);
        logic [4:0] c;
        c = 5'd31;
        for (int b = 10; b >= 0; b--) begin
            if (m[b] && (b != 0 || we)) begin
                c = code_of(b, we); // a clean page only faults on a store.
            end
        end
        return c;
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            $display("ERR %s: got %08h, expected %08h", name, got, exp);
            n_err++;
        end
    endtask

    task automatic end_test(input string name);
        n_tests++;
        if (n_err == err_at_start) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, n_err - err_at_start);
            n_failed++;
        end
        err_at_start = n_err;
    endtask

    task automatic drive_faults(input logic [10:0] m, input logic we);
        data_dirty   <= m[0];
        inst_miss    <= m[1];
        data_miss    <= m[2];
        inst_invalid <= m[3];
        data_invalid <= m[4];
        inst_illegal <= m[5];
        data_illegal <= m[6];
        syscall      <= m[7];
        brk          <= m[8];
        unknown_inst <= m[9];
        overflow     <= m[10];
        data_we      <= we;
    endtask

    task automatic write_cp0(input logic [4:0] a, input logic [31:0] d);
        @(posedge clk);
        mtc0_we   <= 1'b1;
        cp0_addr  <= a;
        cp0_wdata <= d;
        @(posedge clk);
        mtc0_we <= 1'b0;
    endtask

    task automatic read_cp0(input logic [4:0] a, output logic [31:0] d);
        @(posedge clk);
        cp0_addr <= a;
        @(negedge clk);
        d = cp0_rdata;
    endtask

    // one cycle of faults, sampled right after the priority unit registers them.
    task automatic pulse_faults(input logic [10:0] m, input logic we);
        @(posedge clk);
        exc_pc       <= lfsr_bits(32);
        pc           <= lfsr_bits(32);
        data_vaddr   <= lfsr_bits(32);
        in_delayslot <= (lfsr_bits(1) != 32'd0);
        drive_faults(m, we);
        @(posedge clk);
        drive_faults(11'd0, 1'b0);
        @(negedge clk);
    endtask

    task automatic pulse_hw(input int j);
        @(posedge clk);
        hw_int <= 6'd1 << j;
        @(posedge clk);
        hw_int <= 6'd0;
        @(negedge clk);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // scenarios
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic reset_outputs();
        logic [31:0] v;
        @(negedge clk);
        check("flush", 32'(flush), 32'd0);
        check("now_exp", 32'(now_exp), 32'd0);
        check("wr_exp", 32'(u_dut.wr_exp), 32'd0);
        check("clear_exl", 32'(u_dut.clear_exl), 32'd0);
        check("badvaddr_we", 32'(u_dut.badvaddr_we), 32'd0);
        check("exp_code", 32'(u_dut.exp_code), 32'd0);
        read_cp0(cp0_status, v);
        check("status", v, status_reset);
    endtask

    task automatic single_faults(input logic bev);
        logic [31:0] v;
        logic [31:0] exp_pc;
        for (int i = 0; i < 14; i++) begin
            write_cp0(cp0_status, status_word(bev, 8'd0, 1'b0));
            pulse_faults(rows[i].mask, rows[i].we);
            exp_pc = (bev ? boot_base : normal_base) + rows[i].offset;
            check("flush", 32'(flush), 32'd1);
            check("exception_new_pc", exception_new_pc, exp_pc);
            check("exp_code", 32'(u_dut.exp_code), 32'(rows[i].code));
            check("badvaddr_we", 32'(u_dut.badvaddr_we), 32'(rows[i].bv_we));
            read_cp0(cp0_cause, v);
            check("cause_exccode", 32'(v[6:2]), 32'(rows[i].code));
            check("cause_bd", 32'(v[31]), 32'(in_delayslot));
            read_cp0(cp0_epc, v);
            check("epc", v, exc_pc);
            if (rows[i].bv_we) begin
                read_cp0(cp0_badvaddr, v);
                check("badvaddr", v, rows[i].from_pc ? pc : data_vaddr);
            end
            read_cp0(cp0_status, v);
            check("status_exl", 32'(v[1]), 32'd1);
        end
    endtask

    task automatic priority_mix();
        logic [10:0] m;
        logic        we;
        for (int i = 0; i < 40; i++) begin
            m  = 11'(lfsr_bits(11)) | 11'h400; // overflow keeps one fault present.
            we = (lfsr_bits(1) != 32'd0);
            pulse_faults(m, we);
            check("exp_code", 32'(u_dut.exp_code), 32'(top_code(m, we)));
            check("flush", 32'(flush), 32'd1);
        end
    endtask

    task automatic eret_return();
        logic [31:0] v;
        logic [31:0] target;
        pulse_faults(11'h080, 1'b0);
        target = exc_pc;
        @(posedge clk);
        eret <= 1'b1;
        @(negedge clk);
        check("now_exp", 32'(now_exp), 32'd1);
        @(posedge clk);
        eret <= 1'b0;
        @(negedge clk);
        check("flush", 32'(flush), 32'd1);
        check("exception_new_pc", exception_new_pc, target);
        read_cp0(cp0_status, v);
        check("status_exl", 32'(v[1]), 32'd0);
    endtask

    task automatic interrupt_masking();
        int j;
        j = int'(lfsr_bits(3) % 6);
        write_cp0(cp0_status, status_word(1'b0, 8'd1 << (j + 2), 1'b1));
        pulse_hw(j);
        check("flush", 32'(flush), 32'd1);
        check("exp_code", 32'(u_dut.exp_code), 32'(ex_int));
        check("exception_new_pc", exception_new_pc, normal_base + general_offset);
        pulse_hw(j); // exl is set by now.
        check("wr_exp", 32'(u_dut.wr_exp), 32'd0);
        check("flush", 32'(flush), 32'd0);
        write_cp0(cp0_status, status_word(1'b0, 8'd0, 1'b1));
        pulse_hw(j);
        check("wr_exp", 32'(u_dut.wr_exp), 32'd0);
        check("flush", 32'(flush), 32'd0);
    endtask

    task automatic timer_interrupt();
        logic [31:0] cnt;
        int          n;
        write_cp0(cp0_status, status_word(1'b0, 8'h80, 1'b1));
        read_cp0(cp0_count, cnt);
        write_cp0(cp0_compare, cnt + 32'd6);
        n = 0;
        while (!flush && n < 100) begin
            @(negedge clk);
            n++;
        end
        if (!flush) begin
            $display("timer interrupt did not arrive within 100 cycles");
            n_err++;
        end else begin
            check("exp_code", 32'(u_dut.exp_code), 32'(ex_int));
        end
        write_cp0(cp0_compare, 32'hFFFF_FFFF);
        write_cp0(cp0_status, status_word(1'b0, 8'd0, 1'b0));
    endtask

    task automatic flush_release();
        @(posedge clk);
        icache_stall <= 1'b1;
        pulse_faults(11'h080, 1'b0);
        for (int i = 0; i < 4; i++) begin
            check("flush", 32'(flush), 32'd1);
            @(negedge clk);
        end
        @(posedge clk);
        inst_data_ok <= 1'b1;
        @(negedge clk);
        check("flush", 32'(flush), 32'd1);
        @(negedge clk);
        check("flush", 32'(flush), 32'd0);
        @(posedge clk);
        inst_data_ok <= 1'b0;
        icache_stall <= 1'b0;
    endtask

    initial begin
        arst_n        <= 1'b0;
        exc_pc        <= 32'd0;
        pc            <= 32'd0;
        data_vaddr    <= 32'd0;
        eret          <= 1'b0;
        in_delayslot  <= 1'b0;
        inst_data_ok  <= 1'b0;
        icache_stall  <= 1'b0;
        inst_uncached <= 1'b0;
        hw_int        <= 6'd0;
        mtc0_we       <= 1'b0;
        cp0_addr      <= 5'd0;
        cp0_wdata     <= 32'd0;
        drive_faults(11'd0, 1'b0);
        rows[0]  = '{11'h001, 1'b1, ex_mod,  general_offset, 1'b0, 1'b1};
        rows[1]  = '{11'h002, 1'b0, ex_tlbl, refill_offset,  1'b1, 1'b1};
        rows[2]  = '{11'h004, 1'b0, ex_tlbl, refill_offset,  1'b0, 1'b1};
        rows[3]  = '{11'h004, 1'b1, ex_tlbs, refill_offset,  1'b0, 1'b1};
        rows[4]  = '{11'h008, 1'b0, ex_tlbl, general_offset, 1'b1, 1'b1};
        rows[5]  = '{11'h010, 1'b0, ex_tlbl, general_offset, 1'b0, 1'b1};
        rows[6]  = '{11'h010, 1'b1, ex_tlbs, general_offset, 1'b0, 1'b1};
        rows[7]  = '{11'h020, 1'b0, ex_adel, general_offset, 1'b1, 1'b1};
        rows[8]  = '{11'h040, 1'b0, ex_adel, general_offset, 1'b0, 1'b1};
        rows[9]  = '{11'h040, 1'b1, ex_ades, general_offset, 1'b0, 1'b1};
        rows[10] = '{11'h080, 1'b0, ex_sys,  general_offset, 1'b0, 1'b0};
        rows[11] = '{11'h100, 1'b0, ex_bp,   general_offset, 1'b0, 1'b0};
        rows[12] = '{11'h200, 1'b0, ex_ri,   general_offset, 1'b0, 1'b0};
        rows[13] = '{11'h400, 1'b1, ex_ov,   general_offset, 1'b0, 1'b0};
        repeat (8) @(posedge clk);
        arst_n <= 1'b1;
        reset_outputs();
        end_test("reset");
        single_faults(1'b1);
        end_test("single faults, boot vectors");
        single_faults(1'b0);
        end_test("single faults, normal vectors");
        priority_mix();
        end_test("priority");
        eret_return();
        end_test("eret");
        interrupt_masking();
        end_test("interrupt masking");
        timer_interrupt();
        end_test("timer interrupt");
        flush_release();
        end_test("flush release");
        $display("tests %0d, failed %0d, checks %0d, errors %0d, assertion failures %0d",
                 n_tests, n_failed, n_checks, n_err, u_dut.u_chk.fails);
        if (n_err == 0 && u_dut.u_chk.fails == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* verilog.f */
src/exc_pkg.sv
src/exc_priority.sv
src/cp0_regs.sv
src/exc_top.sv
test/exc_checker.sv
test/exc_tb.sv
